/* Bender.yml */
package:
  name: rvCore

sources:
  - design/rvPkg.sv
  - design/immGenerator.sv
  - design/registerFile.sv
  - design/aluControl.sv
  - design/aluUnit.sv
  - design/nextPcLogic.sv
  - design/datapath.sv
  - design/controlUnit.sv
  - design/rvCore.sv
  - target: simulation
    files:
      - verif/wbMemoryModel.sv
      - verif/rvCoreTb.sv

/* design/aluControl.sv */
`default_nettype none

module aluControl (
    input  rvPkg::aluClassT aluClass,
    input  logic [2:0]      funct3,
    input  logic [6:0]      funct7,
    output rvPkg::aluOpT    aluOp
);
    import rvPkg::*;

    always_comb begin
        case (aluClass)
            CLS_ADDR:   aluOp = ALU_ADD;             // base + offset
            CLS_BRANCH: aluOp = ALU_SUB;             // flags come from rs1 - rs2
            default: begin                           // reg and imm ops decode funct3
                case (funct3)
                    3'b000: begin
                        // only r-type has sub, addi reuses bit 30 as immediate
                        aluOp = (aluClass == CLS_REG && funct7[5]) ? ALU_SUB : ALU_ADD;
                    end
                    3'b110:  aluOp = ALU_OR;
                    3'b111:  aluOp = ALU_AND;
                    default: aluOp = ALU_PASSB;      // unsupported funct3
                endcase
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/aluUnit.sv */
`default_nettype none

module aluUnit (
    input  logic [rvPkg::XLEN-1:0] a,
    input  logic [rvPkg::XLEN-1:0] rs2Val,
    input  logic [rvPkg::XLEN-1:0] offset,
    input  logic                   useOffset,
    input  rvPkg::aluOpT           aluOp,
    output logic [rvPkg::XLEN-1:0] result,
    output logic                   zero,
    output logic                   negative,
    output logic                   lessThan
);
    import rvPkg::*;

    logic [XLEN-1:0] b;
    logic            overflow;                       // signed overflow of a - b

    assign b = useOffset ? offset : rs2Val;          // immediate or register operand

    always_comb begin
        case (aluOp)
            ALU_ADD:   result = a + b;
            ALU_SUB:   result = a - b;
            ALU_AND:   result = a & b;
            ALU_OR:    result = a | b;
            ALU_PASSB: result = b;
            default:   result = '0;
        endcase
    end

    assign zero     = (result == '0);
    assign negative = result[XLEN-1];

    // operands of opposite sign and result sign differs from a
    assign overflow = (a[XLEN-1] ^ b[XLEN-1]) & (a[XLEN-1] ^ result[XLEN-1]);
    assign lessThan = negative ^ overflow;           // signed a < b, valid for ALU_SUB only

endmodule

`default_nettype wire

/* design/controlUnit.sv */
`default_nettype none

module controlUnit (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [6:0]             opcode,
    input  logic                   ack,
    input  logic [rvPkg::XLEN-1:0] datRd,
    input  logic [rvPkg::PCW-1:0]  pc,
    input  logic [rvPkg::PCW-1:0]  memAddr,
    output logic                   cyc,
    output logic                   stb,
    output logic                   we,
    output logic [rvPkg::PCW-1:0]  adr,
    output logic                   pcLoad,
    output logic                   irLoad,
    output logic                   rfLoad,
    output rvPkg::aluClassT        aluClass,
    output logic                   useOffset,
    output rvPkg::wbSelT           wbSel,
    output logic                   jal,
    output logic                   jalr,
    output logic                   branch,
    output logic [rvPkg::PCW-1:0]  instrWord
);
    import rvPkg::*;

    cpuStateT state, stateNext;
    logic     done;                                  // bus cycle ends this clock
    logic     busNext;                               // next state owns the bus
    logic     isMem, writesRd;

    assign done      = cyc && ack;
    assign jal       = (opcode == OPC_JAL);
    assign jalr      = (opcode == OPC_JALR);
    assign branch    = (opcode == OPC_BRANCH);
    assign isMem     = (opcode == OPC_LOAD) || (opcode == OPC_STORE);
    assign writesRd  = opcode inside {OPC_RTYPE, OPC_ITYPE, OPC_LOAD, OPC_AUIPC};
    assign useOffset = opcode inside {OPC_ITYPE, OPC_LOAD, OPC_STORE, OPC_JALR};

    // selects follow the ir, so they hold through memory wait states
    always_comb begin
        aluClass = CLS_ADDR;
        wbSel    = WB_ALU;
        case (opcode)
            OPC_RTYPE:         aluClass = CLS_REG;
            OPC_ITYPE:         aluClass = CLS_IMM;
            OPC_BRANCH:        aluClass = CLS_BRANCH;
            OPC_LOAD:          wbSel    = WB_MEM;
            OPC_JAL, OPC_JALR: wbSel    = WB_PC4;
            OPC_AUIPC:         wbSel    = WB_PCIMM;
            default:           ;
        endcase
    end

    always_comb begin
        stateNext = state;
        case (state)
            ST_FETCH:   if (done) stateNext = ST_DECODE;
            ST_DECODE:  stateNext = ST_EXECUTE;      // register reads settle
            ST_EXECUTE: begin
                if (isMem) stateNext = ST_MEMORY;
                else if (branch || jal || jalr) stateNext = ST_FETCH;
                else stateNext = ST_WRITEBACK;
            end
            ST_MEMORY:  if (done) stateNext = ST_WRITEBACK;
            default:    stateNext = ST_FETCH;        // writeback and illegal codes
        endcase
    end

    assign busNext = (stateNext == ST_FETCH) || (stateNext == ST_MEMORY);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_FETCH;
            cyc   <= 1'b0;
            stb   <= 1'b0;
            we    <= 1'b0;
        end else begin
            state <= stateNext;
            cyc   <= busNext;                        // falls the cycle after ack
            stb   <= busNext;
            we    <= (stateNext == ST_MEMORY) && (opcode == OPC_STORE);
        end
    end

    // jumps link and redirect on the same edge, old pc still feeds pc+4
    assign irLoad = (state == ST_FETCH) && done;
    assign pcLoad = ((state == ST_EXECUTE) && (branch || jal || jalr))
                 || (state == ST_WRITEBACK);
    assign rfLoad = ((state == ST_EXECUTE) && (jal || jalr))
                 || ((state == ST_WRITEBACK) && writesRd);

    assign adr       = (state == ST_MEMORY) ? memAddr : {pc[PCW-1:3], 3'b000};
    assign instrWord = pc[2] ? datRd[PCW +: PCW] : datRd[0 +: PCW];  // half holding pc

    stbWithinCyc: assert property (@(posedge clk) disable iff (reset) stb |-> cyc)
        else $error("controlUnit: stb without cyc");

    // address and direction held until the slave answers
    adrHeld: assert property (@(posedge clk) disable iff (reset)
        stb && !ack |=> $stable(adr) && $stable(we))
        else $error("controlUnit: adr/we changed during a stalled cycle");

endmodule

`default_nettype wire

/* design/datapath.sv */
`default_nettype none

module datapath (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   pcLoad,
    input  logic                   irLoad,
    input  logic                   rfLoad,
    input  rvPkg::aluClassT        aluClass,
    input  logic                   useOffset,
    input  rvPkg::wbSelT           wbSel,
    input  logic                   jal,
    input  logic                   jalr,
    input  logic                   branch,
    input  logic [rvPkg::PCW-1:0]  instrWord,
    input  logic [rvPkg::XLEN-1:0] busRdData,
    output logic [6:0]             opcode,
    output logic                   branchTaken,
    output logic [rvPkg::PCW-1:0]  pc,
    output logic [rvPkg::PCW-1:0]  memAddr,
    output logic [rvPkg::XLEN-1:0] storeData
);
    import rvPkg::*;

    logic [PCW-1:0]  ir;
    logic [PCW-1:0]  nextPc;
    logic [4:0]      rs1, rs2, rd;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm, rs1Val, rs2Val;
    logic [XLEN-1:0] aluResult, rfData;
    logic [XLEN-1:0] memDataQ;                       // bus data of the previous cycle
    aluOpT           aluOp;
    logic            zero, lessThan;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;                                // boot from address 0
            ir <= '0;
        end else begin
            if (pcLoad) pc <= nextPc;
            if (irLoad) ir <= instrWord;             // fetch ack cycle
        end
    end

    // ld data is valid only with ack, writeback uses it one cycle later
    always_ff @(posedge clk) begin
        memDataQ <= busRdData;
    end

    assign opcode    = ir[6:0];
    assign memAddr   = aluResult[PCW-1:0];           // rs1 + offset for ld/sd
    assign storeData = rs2Val;

    immGenerator u_immGenerator (
        .instr(ir), .rs1(rs1), .rs2(rs2), .rd(rd),
        .funct3(funct3), .funct7(funct7), .imm(imm)
    );

    registerFile u_registerFile (
        .clk(clk), .reset(reset), .rs1(rs1), .rs2(rs2), .rd(rd), .we(rfLoad),
        .wData(rfData), .rData1(rs1Val), .rData2(rs2Val)
    );

    aluControl u_aluControl (
        .aluClass(aluClass), .funct3(funct3), .funct7(funct7), .aluOp(aluOp)
    );

    aluUnit u_aluUnit (
        .a(rs1Val), .rs2Val(rs2Val), .offset(imm), .useOffset(useOffset), .aluOp(aluOp),
        .result(aluResult), .zero(zero), .negative(), .lessThan(lessThan)
    );

    nextPcLogic u_nextPcLogic (
        .pc(pc), .rs1Val(rs1Val), .imm(imm), .aluResult(aluResult), .memData(memDataQ),
        .funct3(funct3), .zero(zero), .lessThan(lessThan), .jal(jal), .jalr(jalr),
        .branch(branch), .wbSel(wbSel), .nextPc(nextPc), .branchTaken(branchTaken),
        .rfData(rfData)
    );

    // targets from branch, jal and jalr must keep word alignment
    pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("datapath: misaligned pc %h", pc);

endmodule

`default_nettype wire

/* design/immGenerator.sv */
`default_nettype none

module immGenerator (
    input  logic [rvPkg::PCW-1:0]  instr,
    output logic [4:0]             rs1,
    output logic [4:0]             rs2,
    output logic [4:0]             rd,
    output logic [2:0]             funct3,
    output logic [6:0]             funct7,
    output logic [rvPkg::XLEN-1:0] imm
);
    import rvPkg::*;

    logic sign;                                      // instr bit 31 is the sign in every format

    assign sign   = instr[PCW-1];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    always_comb begin
        case (instr[6:0])
            OPC_ITYPE, OPC_LOAD, OPC_JALR: begin     // i-format
                imm = {{(XLEN-12){sign}}, instr[31:20]};
            end
            OPC_STORE: begin                         // s-format, offset split around rd field
                imm = {{(XLEN-12){sign}}, instr[31:25], instr[11:7]};
            end
            OPC_BRANCH: begin                        // b-format, halfword offset
                imm = {{(XLEN-12){sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            OPC_JAL: begin                           // j-format
                imm = {{(XLEN-20){sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            OPC_AUIPC: begin                         // u-format, upper 20 bits
                imm = {{(XLEN-32){sign}}, instr[31:12], 12'b0};
            end
            default: imm = '0;                       // r-type and unknown opcodes
        endcase
    end

endmodule

`default_nettype wire

/* design/nextPcLogic.sv */
`default_nettype none

module nextPcLogic (
    input  logic [rvPkg::PCW-1:0]  pc,
    input  logic [rvPkg::XLEN-1:0] rs1Val,
    input  logic [rvPkg::XLEN-1:0] imm,
    input  logic [rvPkg::XLEN-1:0] aluResult,
    input  logic [rvPkg::XLEN-1:0] memData,
    input  logic [2:0]             funct3,
    input  logic                   zero,
    input  logic                   lessThan,
    input  logic                   jal,
    input  logic                   jalr,
    input  logic                   branch,
    input  rvPkg::wbSelT           wbSel,
    output logic [rvPkg::PCW-1:0]  nextPc,
    output logic                   branchTaken,
    output logic [rvPkg::XLEN-1:0] rfData
);
    import rvPkg::*;

    logic [PCW-1:0] pcPlus4;
    logic [PCW-1:0] pcPlusImm;                       // branch and jal target
    logic [PCW-1:0] jalrSum;
    logic           cond;

    assign pcPlus4   = pc + PCW'(4);
    assign pcPlusImm = pc + imm[PCW-1:0];
    assign jalrSum   = rs1Val[PCW-1:0] + imm[PCW-1:0];

    always_comb begin
        case (funct3)
            3'b000:  cond = zero;                    // beq
            3'b001:  cond = !zero;                   // bne
            3'b100:  cond = lessThan;                // blt
            3'b101:  cond = !lessThan;               // bge
            default: cond = 1'b0;                    // unsigned compares not supported
        endcase
    end

    assign branchTaken = branch && cond;

    always_comb begin
        if (jalr) begin
            nextPc = {jalrSum[PCW-1:1], 1'b0};       // jalr clears bit 0
        end else if (jal || branchTaken) begin
            nextPc = pcPlusImm;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_comb begin
        case (wbSel)
            WB_ALU:   rfData = aluResult;
            WB_MEM:   rfData = memData;
            WB_PC4:   rfData = {{(XLEN-PCW){1'b0}}, pcPlus4};
            WB_PCIMM: rfData = {{(XLEN-PCW){1'b0}}, pc} + imm;   // full width auipc sum
            default:  rfData = aluResult;
        endcase
    end

endmodule

`default_nettype wire

/* design/registerFile.sv */
`default_nettype none

module registerFile (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [4:0]             rs1,
    input  logic [4:0]             rs2,
    input  logic [4:0]             rd,
    input  logic                   we,
    input  logic [rvPkg::XLEN-1:0] wData,
    output logic [rvPkg::XLEN-1:0] rData1,
    output logic [rvPkg::XLEN-1:0] rData2
);
    import rvPkg::*;

    logic [XLEN-1:0] regs [1:31];                    // x0 has no storage

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin         // x0 writes dropped
            regs[rd] <= wData;
        end
    end

    assign rData1 = (rs1 == 5'd0) ? '0 : regs[rs1];  // async read
    assign rData2 = (rs2 == 5'd0) ? '0 : regs[rs2];

    // an X here means a write-back source was never valid
    rData1Known: assert property (@(posedge clk) disable iff (reset) !$isunknown(rData1))
        else $error("registerFile: rData1 unknown for rs1=%0d", rs1);

endmodule

`default_nettype wire

/* design/rvCore.sv */
`default_nettype none

module rvCore (
    input  logic                   clk,
    input  logic                   reset,
    output logic                   cyc,
    output logic                   stb,
    output logic                   we,
    output logic [rvPkg::PCW-1:0]  adr,
    output logic [rvPkg::XLEN-1:0] datWr,
    input  logic [rvPkg::XLEN-1:0] datRd,
    input  logic                   ack
);
    import rvPkg::*;

    logic [6:0]     opcode;
    logic [PCW-1:0] pc, memAddr, instrWord;
    logic           pcLoad, irLoad, rfLoad;
    logic           useOffset, jal, jalr, branch;
    aluClassT       aluClass;
    wbSelT          wbSel;

    controlUnit u_controlUnit (
        .clk(clk), .reset(reset), .opcode(opcode), .ack(ack), .datRd(datRd),
        .pc(pc), .memAddr(memAddr), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .pcLoad(pcLoad), .irLoad(irLoad), .rfLoad(rfLoad), .aluClass(aluClass),
        .useOffset(useOffset), .wbSel(wbSel), .jal(jal), .jalr(jalr),
        .branch(branch), .instrWord(instrWord)
    );

    datapath u_datapath (
        .clk(clk), .reset(reset), .pcLoad(pcLoad), .irLoad(irLoad), .rfLoad(rfLoad),
        .aluClass(aluClass), .useOffset(useOffset), .wbSel(wbSel), .jal(jal),
        .jalr(jalr), .branch(branch), .instrWord(instrWord), .busRdData(datRd),
        .opcode(opcode), .branchTaken(), .pc(pc), .memAddr(memAddr),
        .storeData(datWr)                            // rs2 goes out as sd data
    );

endmodule

`default_nettype wire

/* design/rvPkg.sv */
`default_nettype none

package rvPkg;

    localparam int XLEN = 64;                        // register and data width
    localparam int PCW  = 32;                        // pc, instruction and bus address width

    // base opcodes of the supported subset
    localparam logic [6:0] OPC_RTYPE  = 7'b0110011;  // add sub and or
    localparam logic [6:0] OPC_ITYPE  = 7'b0010011;  // addi and friends
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;  // ld
    localparam logic [6:0] OPC_STORE  = 7'b0100011;  // sd
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;  // beq bne blt bge
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_PASSB                                    // second operand straight through
    } aluOpT;

    typedef enum logic [1:0] {
        CLS_ADDR,                                    // add for load/store/jump addresses
        CLS_BRANCH,                                  // subtract to compare
        CLS_REG,                                     // decode funct3/funct7 of r-type
        CLS_IMM                                      // decode funct3 of i-type
    } aluClassT;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4,                                      // link value of jal/jalr
        WB_PCIMM                                     // auipc
    } wbSelT;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_DECODE,
        ST_EXECUTE,
        ST_MEMORY,
        ST_WRITEBACK
    } cpuStateT;

endpackage

`default_nettype wire

/* rvCore.f */
design/rvPkg.sv
design/immGenerator.sv
design/registerFile.sv
design/aluControl.sv
design/aluUnit.sv
design/nextPcLogic.sv
design/datapath.sv
design/controlUnit.sv
design/rvCore.sv
verif/wbMemoryModel.sv
verif/rvCoreTb.sv

/* verif/rvCoreTb.sv */
`default_nettype none

module rvCoreTb;
    import rvPkg::*;

    localparam int          PERIOD = 8;
    localparam int          NROWS  = 8;
    localparam int          WORDS  = 64;
    localparam logic [31:0] HALT   = 32'h1F8;
    localparam logic [31:0] NOP    = 32'h0000_0013;  // addi x0, x0, 0
    localparam logic [31:0] SEED   = 32'hd5e9_0eec;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        cyc, stb, we, ack;
    logic [31:0] adr;
    logic [63:0] datWr, datRd;

    logic [31:0] progTab [NROWS][8];
    logic [63:0] preVal [NROWS];                     // data word at 0x100 read by row 3
    logic [31:0] expAddr [NROWS][4];
    logic [63:0] expVal [NROWS][4];
    int          expCnt [NROWS];
    string       names [NROWS];
    int          cur = 0;
    int          errCount = 0;
    int          passCount = 0;
    int          failCount = 0;

    always #(PERIOD/2) clk = ~clk;

    rvCore u_rvCore (
        .clk(clk), .reset(reset), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .datWr(datWr), .datRd(datRd), .ack(ack)
    );

    wbMemoryModel #(.SEED(SEED), .WORDS(WORDS)) u_mem (
        .clk(clk), .reset(reset), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .datWr(datWr), .datRd(datRd), .ack(ack)
    );

    // small assembler for the supported formats
    function automatic logic [31:0] rType(int f7, int rd, int f3, int rs1, int rs2);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), OPC_RTYPE};
    endfunction

    function automatic logic [31:0] iType(logic [6:0] op, int rd, int f3, int rs1, int imm);
        return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), op};
    endfunction

    function automatic logic [31:0] sType(int rs2, int rs1, int imm);
        logic [11:0] im;
        im = 12'(imm);
        return {im[11:5], 5'(rs2), 5'(rs1), 3'b011, im[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] bType(int f3, int rs1, int rs2, int imm);
        logic [12:0] im;
        im = 13'(imm);
        return {im[12], im[10:5], 5'(rs2), 5'(rs1), 3'(f3), im[4:1], im[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] jType(int rd, int imm);
        logic [20:0] im;
        im = 21'(imm);
        return {im[20], im[10:1], im[11], im[19:12], 5'(rd), OPC_JAL};
    endfunction

    function automatic logic [31:0] uType(int rd, int imm20);
        return {20'(imm20), 5'(rd), OPC_AUIPC};
    endfunction

    task automatic buildTable();
        logic [31:0] halt;
        halt = sType(0, 0, HALT);                    // sd x0, 0x1f8(x0)
        for (int r = 0; r < NROWS; r++) preVal[r] = 64'h0;
        names[0] = "add/sub";
        progTab[0] = '{iType(OPC_ITYPE, 1, 0, 0, 12), iType(OPC_ITYPE, 2, 0, 0, 10),
            rType(0, 3, 0, 1, 2), rType(32, 4, 0, 1, 2), sType(3, 0, 256), sType(4, 0, 264),
            halt, NOP};
        expCnt[0] = 2;
        expAddr[0] = '{256, 264, 0, 0};
        expVal[0] = '{22, 2, 0, 0};
        names[1] = "and/or/x0";
        progTab[1] = '{iType(OPC_ITYPE, 1, 0, 0, 12), iType(OPC_ITYPE, 2, 0, 0, 10),
            rType(0, 3, 7, 1, 2), rType(0, 0, 6, 1, 2), rType(0, 4, 6, 0, 2),
            sType(3, 0, 256), sType(4, 0, 264), halt};
        expCnt[1] = 2;
        expAddr[1] = '{256, 264, 0, 0};
        expVal[1] = '{8, 10, 0, 0};                  // x0 stays zero so or gives 10
        names[2] = "sign extension";
        progTab[2] = '{iType(OPC_ITYPE, 1, 0, 0, -5), iType(OPC_ITYPE, 2, 0, 0, 272),
            sType(1, 2, -8), iType(OPC_ITYPE, 3, 0, 1, -3), sType(3, 2, -16), halt, NOP, NOP};
        expCnt[2] = 2;
        expAddr[2] = '{264, 256, 0, 0};
        expVal[2] = '{64'hFFFF_FFFF_FFFF_FFFB, 64'hFFFF_FFFF_FFFF_FFF8, 0, 0};
        names[3] = "load/store/auipc";
        preVal[3] = 64'h1234_5678_9ABC_DEF0;
        progTab[3] = '{iType(OPC_LOAD, 1, 3, 0, 256), iType(OPC_ITYPE, 2, 0, 1, 100),
            sType(2, 0, 264), uType(3, 20'hFFFFF), sType(3, 0, 272), halt, NOP, NOP};
        expCnt[3] = 2;
        expAddr[3] = '{264, 272, 0, 0};
        expVal[3] = '{64'h1234_5678_9ABC_DF54, 64'hFFFF_FFFF_FFFF_F00C, 0, 0};  // 12 - 4096
        names[4] = "beq/bne";
        progTab[4] = '{iType(OPC_ITYPE, 1, 0, 0, -1), iType(OPC_ITYPE, 2, 0, 0, 1),
            bType(0, 1, 2, 12), bType(1, 1, 1, 8), sType(1, 0, 256), bType(1, 1, 2, 8),
            sType(2, 0, 264), halt};
        expCnt[4] = 1;
        expAddr[4] = '{256, 0, 0, 0};
        expVal[4] = '{64'hFFFF_FFFF_FFFF_FFFF, 0, 0, 0};
        names[5] = "blt/bge";
        progTab[5] = '{iType(OPC_ITYPE, 1, 0, 0, -1), iType(OPC_ITYPE, 2, 0, 0, 1),
            bType(4, 2, 1, 12), bType(5, 1, 2, 8), sType(1, 0, 256), bType(4, 1, 2, 8),
            sType(2, 0, 264), halt};
        expCnt[5] = 1;
        expAddr[5] = '{256, 0, 0, 0};
        expVal[5] = '{64'hFFFF_FFFF_FFFF_FFFF, 0, 0, 0};
        names[6] = "taken bge/beq";
        progTab[6] = '{iType(OPC_ITYPE, 1, 0, 0, -1), bType(5, 1, 1, 8), sType(1, 0, 256),
            bType(0, 0, 0, 8), sType(1, 0, 264), sType(1, 0, 272), halt, NOP};
        expCnt[6] = 1;
        expAddr[6] = '{272, 0, 0, 0};
        expVal[6] = '{64'hFFFF_FFFF_FFFF_FFFF, 0, 0, 0};
        names[7] = "jal/jalr";
        progTab[7] = '{jType(1, 8), sType(0, 0, 288), sType(1, 0, 256),
            iType(OPC_JALR, 2, 0, 1, 16), sType(0, 0, 296), sType(2, 0, 264), halt, NOP};
        expCnt[7] = 2;
        expAddr[7] = '{256, 264, 0, 0};
        expVal[7] = '{4, 16, 0, 0};                  // link values pc+4
    endtask

    task automatic loadMemory(int t);
        for (int i = 0; i < WORDS; i++) begin
            u_mem.mem[i] = {16'hA5A5, 16'(i), 16'(i * 8), 16'h5A5A};   // address tagged fill
        end
        for (int i = 0; i < 4; i++) begin
            u_mem.mem[i] = {progTab[t][2*i+1], progTab[t][2*i]};   // odd slot in upper half
        end
        u_mem.mem[256/8] = preVal[t];
    endtask

    task automatic runTest(int t);
        int          nStores;
        int          errBefore;
        bit          halted;
        bit          lastStall;
        logic        lastWe;
        logic [31:0] lastAdr;
        nStores   = 0;
        errBefore = errCount;
        halted    = 0;
        lastStall = 0;
        lastWe    = 1'b0;
        lastAdr   = '0;
        loadMemory(t);
        @(negedge clk) reset = 1'b1;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        while (!halted) begin
            @(negedge clk);
            assert (!stb || cyc) else begin
                $display("test %0d: stb high without cyc at time %0t", t, $time);
                errCount++;
            end
            if (lastStall) begin                     // stalled cycle keeps its address
                assert (adr == lastAdr) else begin
                    $display("ERROR %0t adr expected %h actual %h", $time, lastAdr, adr);
                    errCount++;
                end
                assert (we == lastWe) else begin
                    $display("ERROR %0t we expected %b actual %b", $time, lastWe, we);
                    errCount++;
                end
            end
            lastStall = stb && !ack;
            lastAdr   = adr;
            lastWe    = we;
            if (cyc && stb && we && ack) begin
                if (adr == HALT) begin
                    halted = 1;
                end else begin
                    assert (nStores < expCnt[t]) else begin
                        $display("test %0d: unexpected store of %h to address %h", t,
                            datWr, adr);
                        errCount++;
                    end
                    if (nStores < expCnt[t]) begin
                        assert (adr == expAddr[t][nStores]) else begin
                            $display("ERROR %0t adr expected %h actual %h", $time,
                                expAddr[t][nStores], adr);
                            errCount++;
                        end
                        assert (datWr == expVal[t][nStores]) else begin
                            $display("ERROR %0t datWr expected %h actual %h", $time,
                                expVal[t][nStores], datWr);
                            errCount++;
                        end
                    end
                    nStores++;
                end
            end
        end
        assert (nStores >= expCnt[t]) else begin
            $display("test %0d: only %0d of %0d stores seen before halt", t, nStores,
                expCnt[t]);
            errCount++;
        end
        if (errCount == errBefore) begin
            passCount++;
            $display("test %0d %s: pass", t, names[t]);
        end else begin
            failCount++;
            $display("test %0d %s: fail", t, names[t]);
        end
    endtask

    initial begin
        buildTable();
        for (int t = 0; t < NROWS; t++) begin
            cur = t;
            runTest(t);
        end
        $display("tests passed %0d, failed %0d, check errors %0d", passCount, failCount,
            errCount);
        if (failCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // every row gets 200 cycles of budget
    initial begin
        #(NROWS * 200 * PERIOD);
        $display("watchdog: test %0d (%s) never reached the halt store", cur, names[cur]);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/wbMemoryModel.sv */
`default_nettype none

module wbMemoryModel #(
    parameter int SEED  = 0,                         // wait-state sequence
    parameter int WORDS = 64                         // 64-bit words, 512 bytes
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [31:0] adr,
    input  logic [63:0] datWr,
    output logic [63:0] datRd,
    output logic        ack
);
    localparam int AW = $clog2(WORDS);

    logic [63:0]   mem [0:WORDS-1];                  // loaded by the testbench
    logic [AW-1:0] idx;
    int            seed;
    int            waitLeft;                         // wait states left for this access

    initial seed = SEED;

    assign idx   = adr[3 +: AW];                     // byte address to word index
    assign datRd = mem[idx];

    always @(posedge clk) begin
        if (reset) begin
            ack      <= 1'b0;
            waitLeft <= 0;
        end else if (ack) begin
            ack <= 1'b0;                             // single cycle ack
        end else if (cyc && stb) begin
            if (waitLeft == 0) ack <= 1'b1;
            else waitLeft <= waitLeft - 1;
        end else begin
            waitLeft <= $unsigned($random(seed)) % 4;   // 0 to 3 waits for the next access
        end
        if (!reset && cyc && stb && we && ack) mem[idx] <= datWr;
    end

endmodule

`default_nettype wire
